/* tb/mcpu_stim.txt */
# i <program word, hex>   s <store address, hex> <store data, hex>
# r <register index, dec> <expected final value, hex>; index 0 reads the pc
i 20010005  # 00 addi $1, $0, 5
i 2002000e  # 01 addi $2, $0, 14
i 00221820  # 02 add  $3, $1, $2      forward from mem and wb
i 00612022  # 03 sub  $4, $3, $1
i 00832824  # 04 and  $5, $4, $3
i 00a13025  # 05 or   $6, $5, $1
i 00c4382a  # 06 slt  $7, $6, $4
i 2008fffd  # 07 addi $8, $0, -3
i 0107482a  # 08 slt  $9, $8, $7      signed compare
i ac660004  # 09 sw   $6, 4($3)
i 8c6a0004  # 0a lw   $10, 4($3)
i 01495820  # 0b add  $11, $10, $9    load-use stall
i ac0b0000  # 0c sw   $11, 0($0)
i 200c0064  # 0d addi $12, $0, 100
i 218dff9c  # 0e addi $13, $12, -100
i 11a00001  # 0f beq  $13, $0, +1     branch stall then taken
i 200c0037  # 10 addi $12, $0, 55     flushed
i 14820001  # 11 bne  $4, $2, +1      not taken
i 200e0021  # 12 addi $14, $0, 33
i 20000009  # 13 addi $0, $0, 9
i adc00008  # 14 sw   $0, 8($14)
i 000e7820  # 15 add  $15, $0, $14
i 1000ffff  # 16 beq  $0, $0, -1      halt
s 00000017 00000007
s 00000000 00000008
s 00000029 00000000
r 0 00000016
r 1 00000005
r 2 0000000e
r 3 00000013
r 4 0000000e
r 5 00000002
r 6 00000007
r 7 00000001
r 8 fffffffd
r 9 00000001
r 10 00000007
r 11 00000008
r 12 00000064
r 13 00000000
r 14 00000021
r 15 00000021

/* build.f */
src/mcpu_pkg.sv
src/mcpu_regfile.sv
src/mcpu_control.sv
src/mcpu_alu.sv
src/mcpu_hazard.sv
src/mcpu_core.sv
tb/mcpu_tb.sv

/* run.sh */
#!/bin/sh
# build the mcpu testbench with Verilator and run it from the project root
cd "$(dirname "$0")" \
    && verilator --binary --timing --top-module mcpu_tb -f build.f -o mcpu_sim \
    && ./obj_dir/mcpu_sim | tee /dev/stderr | grep -q "SIMULATION PASSED" \
    && echo "run.sh: test run passed" \
    || { echo "run.sh: test run failed"; exit 1; }

/* tb/mcpu_tb.sv */
// mcpu testbench: runs the stim program, checks every store and the final registers
`timescale 1ns/1ps
`default_nettype none

module mcpu_tb;

    logic        clk;
    logic        rst;
    logic [4:0]  reg_addr;
    logic [31:0] reg_data;
    logic [31:0] im_addr;
    logic [31:0] im_data;
    logic [31:0] dm_addr;
    logic        dm_we;
    logic [31:0] dm_wdata;
    logic [31:0] dm_rdata;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] exp_st_addr [$];
    logic [31:0] exp_st_data [$];
    logic [4:0]  exp_reg_idx [$];
    logic [31:0] exp_reg_val [$];
    int          errors;
    int          store_cnt;
    logic [7:0]  prog_len;

    mcpu_core dut_i (
        .clk      (clk),
        .rst      (rst),
        .reg_addr (reg_addr),
        .reg_data (reg_data),
        .im_addr  (im_addr),
        .im_data  (im_data),
        .dm_addr  (dm_addr),
        .dm_we    (dm_we),
        .dm_wdata (dm_wdata),
        .dm_rdata (dm_rdata)
    );

    // **********************************************************************
    // memory models, both answer in the same cycle
    // **********************************************************************

    assign im_data  = imem[im_addr[7:0]];
    assign dm_rdata = dmem[dm_addr[7:0]];

    always @(posedge clk) begin
        if (dm_we) begin
            dmem[dm_addr[7:0]] <= dm_wdata;
        end
    end

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // stores are compared in program order
    always @(negedge clk) begin
        if (!rst && dm_we) begin
            if (store_cnt < exp_st_addr.size()) begin
                check_value($sformatf("store %0d addr", store_cnt), exp_st_addr[store_cnt], dm_addr);
                check_value($sformatf("store %0d data", store_cnt), exp_st_data[store_cnt], dm_wdata);
            end else begin
                errors++;
                $display("unexpected extra store to address %h", dm_addr);
            end
            store_cnt++;
        end
    end

    // tag i: program word, tag s: store address and data, tag r: register and value
    task automatic load_stim(output bit ok);
        int               fd;
        int               code;
        int               idx;
        logic [63:0]      tag;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [8*128-1:0] rest;
        ok = 1'b0;
        fd = $fopen("tb/mcpu_stim.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while ($fscanf(fd, "%s", tag) == 1) begin
                code = 2;
                if (tag == "#") begin
                    code = $fgets(rest, fd);    // comment, rest of line
                    code = 2;
                end else if (tag == "i") begin
                    code = $fscanf(fd, "%h", a) + 1;
                    imem[prog_len] = a;
                    prog_len++;
                end else if (tag == "s") begin
                    code = $fscanf(fd, "%h %h", a, b);
                    exp_st_addr.push_back(a);
                    exp_st_data.push_back(b);
                end else if (tag == "r") begin
                    code = $fscanf(fd, "%d %h", idx, b);
                    exp_reg_idx.push_back(idx[4:0]);
                    exp_reg_val.push_back(b);
                end else begin
                    code = 0;
                end
                if (code != 2) begin
                    ok = 1'b0;
                end
            end
            $fclose(fd);
        end
    endtask

    // pc alternates between the loop and its flushed successor
    task automatic wait_for_halt_fetch(input logic [31:0] halt_addr, input int limit,
                                       output bit found);
        int cycles;
        cycles = 0;
        found  = 1'b0;
        while (!found && cycles < limit) begin
            @(negedge clk);
            cycles++;
            found = (im_addr == halt_addr);
        end
    endtask

    initial begin
        bit          ok;
        bit          found;
        int          seen;
        logic [31:0] halt_addr;
        errors    = 0;
        store_cnt = 0;
        prog_len  = '0;
        rst       = 1'b1;
        reg_addr  = '0;
        for (int k = 0; k < 256; k++) begin
            imem[k[7:0]] = '0;                  // nop
            dmem[k[7:0]] = 32'hd000_0000 + k;
        end
        load_stim(ok);
        halt_addr = {24'd0, prog_len} - 32'd1;  // last word is the self-branch

        for (int k = 0; k < 3; k++) begin
            @(posedge clk);
            if (k == 2) begin
                rst <= 1'b0;
            end
            @(negedge clk);
            check_value("reset im_addr", 32'd0, im_addr);
            check_value("reset dm_we", 32'd0, {31'd0, dm_we});
        end

        if (!ok) begin
            errors++;
            $display("stim file tb/mcpu_stim.txt is missing or malformed");
        end else begin
            seen  = 0;
            found = 1'b1;
            while (found && seen < 8) begin
                wait_for_halt_fetch(halt_addr, 200, found);
                if (found) begin
                    seen++;
                end
            end
            if (!found) begin
                errors++;
                $display("timeout: program never settled in the halt loop at %h", halt_addr);
            end else begin
                for (int n = 0; n < exp_reg_idx.size(); n++) begin
                    @(posedge clk);
                    reg_addr <= exp_reg_idx[n];
                    wait_for_halt_fetch(halt_addr, 8, found);
                    if (found) begin
                        check_value($sformatf("reg %0d", exp_reg_idx[n]), exp_reg_val[n],
                                    reg_data);
                    end else begin
                        errors++;
                        $display("timeout: halt fetch lost while reading register %0d",
                                 exp_reg_idx[n]);
                    end
                end
                check_value("store count", exp_st_addr.size(), store_cnt);
            end
        end

        $display("errors: %0d, stores seen: %0d, registers checked: %0d",
                 errors, store_cnt, exp_reg_idx.size());
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/mcpu_core.sv */
// mcpu core with a five-stage MIPS subset pipeline, decode branches and forwarding
`timescale 1ns/1ps
`default_nettype none

module mcpu_core (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic [mcpu_pkg::reg_w-1:0]  reg_addr,   // debug register select
    output logic      [mcpu_pkg::word_w-1:0] reg_data,
    output logic      [mcpu_pkg::word_w-1:0] im_addr,
    input  wire logic [mcpu_pkg::word_w-1:0] im_data,
    output logic      [mcpu_pkg::word_w-1:0] dm_addr,
    output logic                             dm_we,
    output logic      [mcpu_pkg::word_w-1:0] dm_wdata,
    input  wire logic [mcpu_pkg::word_w-1:0] dm_rdata
);

    logic                        stall;
    logic                        flush_d;
    logic                        pc_src_d;
    logic                        branch_d;
    logic [mcpu_pkg::word_w-1:0] pc;
    logic [mcpu_pkg::word_w-1:0] pc_next;
    logic [mcpu_pkg::word_w-1:0] pc_next_d;
    logic [mcpu_pkg::word_w-1:0] pc_branch_d;
    mcpu_pkg::instr_u            instr_d;
    mcpu_pkg::ctrl_t             ctrl_d;
    logic [mcpu_pkg::word_w-1:0] rd1_d, rd2_d, dbg_rd;
    logic [mcpu_pkg::word_w-1:0] sign_imm_d;
    logic [mcpu_pkg::word_w-1:0] cmp_a_d, cmp_b_d;
    logic                        fwd_a_d, fwd_b_d;
    mcpu_pkg::fwd_sel_t          fwd_a_e, fwd_b_e;
    mcpu_pkg::de_reg_t           de, de_d;
    mcpu_pkg::em_reg_t           em, em_d;
    mcpu_pkg::mw_reg_t           mw, mw_d;
    logic [mcpu_pkg::reg_w-1:0]  write_reg_e;
    logic [mcpu_pkg::word_w-1:0] src_a_e, src_b_e, write_data_e, alu_result_e;
    logic [mcpu_pkg::word_w-1:0] result_w;

    // **********************************************************************
    // fetch
    // **********************************************************************

    assign pc_next = pc + 32'd1;    // word addressed
    assign im_addr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (!stall) begin
            pc <= pc_src_d ? pc_branch_d : pc_next;
        end
    end

    // all-zero word decodes to empty control
    always_ff @(posedge clk) begin
        if (rst || flush_d) begin
            instr_d <= '0;
        end else if (!stall) begin
            instr_d <= im_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pc_next_d <= pc_next;
        end
    end

    // **********************************************************************
    // decode
    // **********************************************************************

    mcpu_regfile regfile_i (
        .clk      (clk),
        .a1       (instr_d.i.rs),
        .a2       (instr_d.i.rt),
        .a3       (mw.write_reg),
        .dbg_addr (reg_addr),
        .wd3      (result_w),
        .we3      (mw.reg_write),
        .rd1      (rd1_d),
        .rd2      (rd2_d),
        .dbg_data (dbg_rd)
    );

    assign reg_data = (reg_addr != '0) ? dbg_rd : pc;   // address 0 shows the PC

    assign sign_imm_d  = {{16{instr_d.i.imm[15]}}, instr_d.i.imm};
    assign pc_branch_d = pc_next_d + sign_imm_d;

    // early branch compare
    assign cmp_a_d = fwd_a_d ? em.alu_result : rd1_d;
    assign cmp_b_d = fwd_b_d ? em.alu_result : rd2_d;

    mcpu_control control_i (
        .instr  (instr_d),
        .equal  (cmp_a_d == cmp_b_d),
        .ctrl   (ctrl_d),
        .branch (branch_d),
        .pc_src (pc_src_d)
    );

    always_comb begin
        de_d.ctrl     = ctrl_d;
        de_d.rd1      = rd1_d;
        de_d.rd2      = rd2_d;
        de_d.sign_imm = sign_imm_d;
        de_d.rs       = instr_d.i.rs;
        de_d.rt       = instr_d.i.rt;
        de_d.rd       = instr_d.r.rd;
    end

    always_ff @(posedge clk) begin
        de <= de_d;
        if (rst || stall) begin
            de.ctrl <= '0;  // bubble
        end
    end

    // **********************************************************************
    // execute
    // **********************************************************************

    function automatic logic [mcpu_pkg::word_w-1:0] fwd_mux(
        input mcpu_pkg::fwd_sel_t          sel,
        input logic [mcpu_pkg::word_w-1:0] reg_val
    );
        case (sel)
            mcpu_pkg::fwd_mem: return em.alu_result;
            mcpu_pkg::fwd_wb:  return result_w;
            default:           return reg_val;
        endcase
    endfunction

    always_comb begin
        src_a_e      = fwd_mux(fwd_a_e, de.rd1);
        write_data_e = fwd_mux(fwd_b_e, de.rd2);   // also store data
    end

    assign src_b_e      = de.ctrl.alu_src ? de.sign_imm : write_data_e;
    assign write_reg_e  = de.ctrl.reg_dst ? de.rd : de.rt;

    mcpu_alu alu_i (
        .a      (src_a_e),
        .b      (src_b_e),
        .op     (de.ctrl.alu_op),
        .result (alu_result_e)
    );

    always_comb begin
        em_d.reg_write  = de.ctrl.reg_write;
        em_d.mem_write  = de.ctrl.mem_write;
        em_d.mem_to_reg = de.ctrl.mem_to_reg;
        em_d.alu_result = alu_result_e;
        em_d.write_data = write_data_e;
        em_d.write_reg  = write_reg_e;
    end

    always_ff @(posedge clk) begin
        em <= em_d;
        if (rst) begin
            em.reg_write  <= 1'b0;
            em.mem_write  <= 1'b0;
            em.mem_to_reg <= 1'b0;
        end
    end

    // **********************************************************************
    // memory and writeback
    // **********************************************************************

    assign dm_addr  = em.alu_result;
    assign dm_we    = em.mem_write;
    assign dm_wdata = em.write_data;

    always_comb begin
        mw_d.reg_write  = em.reg_write;
        mw_d.mem_to_reg = em.mem_to_reg;
        mw_d.alu_result = em.alu_result;
        mw_d.read_data  = dm_rdata;     // same-cycle memory answer
        mw_d.write_reg  = em.write_reg;
    end

    always_ff @(posedge clk) begin
        mw <= mw_d;
        if (rst) begin
            mw.reg_write  <= 1'b0;
            mw.mem_to_reg <= 1'b0;
        end
    end

    assign result_w = mw.mem_to_reg ? mw.read_data : mw.alu_result;

    mcpu_hazard hazard_i (
        .rs_d        (instr_d.i.rs),
        .rt_d        (instr_d.i.rt),
        .rs_e        (de.rs),
        .rt_e        (de.rt),
        .write_reg_e (write_reg_e),
        .de          (de.ctrl),
        .em          (em),
        .mw          (mw),
        .branch_d    (branch_d),
        .pc_src_d    (pc_src_d),
        .fwd_a_e     (fwd_a_e),
        .fwd_b_e     (fwd_b_e),
        .fwd_a_d     (fwd_a_d),
        .fwd_b_d     (fwd_b_d),
        .stall       (stall),
        .flush_d     (flush_d)
    );

endmodule

`default_nettype wire

/* src/mcpu_hazard.sv */
// mcpu hazard unit that picks forwarding selects and raises stalls and the decode flush
`timescale 1ns/1ps
`default_nettype none

module mcpu_hazard (
    input  wire logic [mcpu_pkg::reg_w-1:0] rs_d,
    input  wire logic [mcpu_pkg::reg_w-1:0] rt_d,
    input  wire logic [mcpu_pkg::reg_w-1:0] rs_e,
    input  wire logic [mcpu_pkg::reg_w-1:0] rt_e,
    input  wire logic [mcpu_pkg::reg_w-1:0] write_reg_e,
    input  wire mcpu_pkg::ctrl_t            de,        // control of execute stage
    input  wire mcpu_pkg::em_reg_t          em,
    input  wire mcpu_pkg::mw_reg_t          mw,
    input  wire logic                       branch_d,
    input  wire logic                       pc_src_d,
    output mcpu_pkg::fwd_sel_t              fwd_a_e,
    output mcpu_pkg::fwd_sel_t              fwd_b_e,
    output logic                            fwd_a_d,
    output logic                            fwd_b_d,
    output logic                            stall,
    output logic                            flush_d
);

    logic load_stall;
    logic branch_stall;

    // memory stage wins over writeback and $0 is never forwarded
    function automatic mcpu_pkg::fwd_sel_t exe_sel(input logic [mcpu_pkg::reg_w-1:0] src);
        if (src == '0) begin
            return mcpu_pkg::fwd_none;
        end
        if (em.reg_write && (em.write_reg == src)) begin
            return mcpu_pkg::fwd_mem;
        end
        if (mw.reg_write && (mw.write_reg == src)) begin
            return mcpu_pkg::fwd_wb;
        end
        return mcpu_pkg::fwd_none;
    endfunction

    always_comb begin
        fwd_a_e = exe_sel(rs_e);
        fwd_b_e = exe_sel(rt_e);
    end

    // branch compare operands from the memory stage alu result
    assign fwd_a_d = (rs_d != '0) && em.reg_write && (em.write_reg == rs_d);
    assign fwd_b_d = (rt_d != '0) && em.reg_write && (em.write_reg == rt_d);

    assign load_stall = de.mem_to_reg && ((rs_d == write_reg_e) || (rt_d == write_reg_e));

    // branch source not ready yet
    assign branch_stall = branch_d && (
           (de.reg_write  && ((rs_d == write_reg_e)  || (rt_d == write_reg_e)))
        || (em.mem_to_reg && ((rs_d == em.write_reg) || (rt_d == em.write_reg))));

    assign stall   = load_stall || branch_stall;
    assign flush_d = pc_src_d && !stall;    // drop the slot behind a taken branch

endmodule

`default_nettype wire

/* src/mcpu_alu.sv */
// mcpu ALU: add, subtract, and, or, signed set-less-than
`timescale 1ns/1ps
`default_nettype none

module mcpu_alu (
    input  wire logic [mcpu_pkg::word_w-1:0] a,
    input  wire logic [mcpu_pkg::word_w-1:0] b,
    input  wire mcpu_pkg::alu_op_t           op,
    output logic      [mcpu_pkg::word_w-1:0] result
);

    always_comb begin
        case (op)
            mcpu_pkg::alu_add: result = a + b;
            mcpu_pkg::alu_sub: result = a - b;
            mcpu_pkg::alu_and: result = a & b;
            mcpu_pkg::alu_or:  result = a | b;
            mcpu_pkg::alu_slt: begin
                // signed compare, 1 or 0
                result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            end
            default:           result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* src/mcpu_control.sv */
// mcpu decode unit: opcode and function field to control word and branch decision
`timescale 1ns/1ps
`default_nettype none

module mcpu_control (
    input  wire mcpu_pkg::instr_u instr,
    input  wire logic             equal,    // operands equal, already forwarded
    output mcpu_pkg::ctrl_t       ctrl,
    output logic                  branch,
    output logic                  pc_src
);

    always_comb begin
        ctrl   = '0;
        branch = 1'b0;
        case (instr.i.op)
            mcpu_pkg::op_rtype: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = 1'b1;
                case (instr.r.funct)
                    mcpu_pkg::fn_add: ctrl.alu_op = mcpu_pkg::alu_add;
                    mcpu_pkg::fn_sub: ctrl.alu_op = mcpu_pkg::alu_sub;
                    mcpu_pkg::fn_and: ctrl.alu_op = mcpu_pkg::alu_and;
                    mcpu_pkg::fn_or:  ctrl.alu_op = mcpu_pkg::alu_or;
                    mcpu_pkg::fn_slt: ctrl.alu_op = mcpu_pkg::alu_slt;
                    default:          ctrl        = '0;     // unknown funct
                endcase
            end
            mcpu_pkg::op_addi: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            mcpu_pkg::op_lw: begin
                ctrl.reg_write  = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            mcpu_pkg::op_sw: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            mcpu_pkg::op_beq,
            mcpu_pkg::op_bne: begin
                branch = 1'b1;  // resolved here in decode
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    assign pc_src = ((instr.i.op == mcpu_pkg::op_beq) &&  equal)
                 || ((instr.i.op == mcpu_pkg::op_bne) && !equal);

endmodule

`default_nettype wire

/* src/mcpu_regfile.sv */
// mcpu register file with 32 x 32 words, two read ports, a debug read and write-through
`timescale 1ns/1ps
`default_nettype none

module mcpu_regfile (
    input  wire logic                          clk,
    input  wire logic [mcpu_pkg::reg_w-1:0]    a1,
    input  wire logic [mcpu_pkg::reg_w-1:0]    a2,
    input  wire logic [mcpu_pkg::reg_w-1:0]    a3,
    input  wire logic [mcpu_pkg::reg_w-1:0]    dbg_addr,
    input  wire logic [mcpu_pkg::word_w-1:0]   wd3,
    input  wire logic                          we3,
    output logic      [mcpu_pkg::word_w-1:0]   rd1,
    output logic      [mcpu_pkg::word_w-1:0]   rd2,
    output logic      [mcpu_pkg::word_w-1:0]   dbg_data
);

    logic [mcpu_pkg::word_w-1:0] regs [32];

    // $0 reads zero and a same-cycle write passes straight through
    function automatic logic [mcpu_pkg::word_w-1:0] read_port(
        input logic [mcpu_pkg::reg_w-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end
        if (we3 && (a3 == addr)) begin
            return wd3;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (we3 && (a3 != '0)) begin
            regs[a3] <= wd3;
        end
    end

    always_comb begin
        rd1      = read_port(a1);
        rd2      = read_port(a2);
        dbg_data = read_port(dbg_addr);
    end

endmodule

`default_nettype wire

/* src/mcpu_pkg.sv */
// mcpu package: instruction encodings, control word and pipeline stage register types
`default_nettype none

package mcpu_pkg;

    localparam int word_w = 32;
    localparam int reg_w  = 5;

    // opcodes
    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_addi  = 6'h08;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_sw    = 6'h2b;
    localparam logic [5:0] op_beq   = 6'h04;
    localparam logic [5:0] op_bne   = 6'h05;

    // R-type function codes
    localparam logic [5:0] fn_add = 6'h20;
    localparam logic [5:0] fn_sub = 6'h22;
    localparam logic [5:0] fn_and = 6'h24;
    localparam logic [5:0] fn_or  = 6'h25;
    localparam logic [5:0] fn_slt = 6'h2a;

    typedef enum logic [2:0] {
        alu_add = 3'd0,     // zero code, so an empty control word adds
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4
    } alu_op_t;

    typedef enum logic [1:0] {
        fwd_none = 2'b00,   // register file value
        fwd_mem  = 2'b01,   // alu result in memory stage
        fwd_wb   = 2'b10    // writeback result
    } fwd_sel_t;

    typedef struct packed {
        logic [5:0]       op;
        logic [reg_w-1:0] rs;
        logic [reg_w-1:0] rt;
        logic [reg_w-1:0] rd;
        logic [4:0]       shamt;
        logic [5:0]       funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]       op;
        logic [reg_w-1:0] rs;
        logic [reg_w-1:0] rt;
        logic [15:0]      imm;
    } i_fields_t;

    // one instruction word, seen either way
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_u;

    typedef struct packed {
        logic    reg_write;
        logic    reg_dst;      // 1: rd, 0: rt
        logic    alu_src;      // 1: immediate
        alu_op_t alu_op;
        logic    mem_write;
        logic    mem_to_reg;
    } ctrl_t;

    typedef struct packed {
        ctrl_t             ctrl;
        logic [word_w-1:0] rd1;
        logic [word_w-1:0] rd2;
        logic [word_w-1:0] sign_imm;
        logic [reg_w-1:0]  rs;
        logic [reg_w-1:0]  rt;
        logic [reg_w-1:0]  rd;
    } de_reg_t;

    typedef struct packed {
        logic              reg_write;
        logic              mem_write;
        logic              mem_to_reg;
        logic [word_w-1:0] alu_result;
        logic [word_w-1:0] write_data;
        logic [reg_w-1:0]  write_reg;
    } em_reg_t;

    typedef struct packed {
        logic              reg_write;
        logic              mem_to_reg;
        logic [word_w-1:0] alu_result;
        logic [word_w-1:0] read_data;
        logic [reg_w-1:0]  write_reg;
    } mw_reg_t;

endpackage

`default_nettype wire
